/* Bender.yml */
package:
  name: dcache

sources:
  - include_dirs:
      - hw
    files:
      - hw/dcache_pkg.sv
      - hw/dcache_array_if.sv
      - hw/dcache_store.sv
      - hw/dcache_ctrl.sv
      - hw/dcache.sv
  - target: test
    files:
      - tests/mem_model.sv
      - tests/dcache_tb.sv

/* hw/dcache.sv */
// write-back data cache
`default_nettype none
`include "dcache_cfg.svh"

module dcache (
	input logic CLK,
	input logic nRST,
	// cpu side
	input logic req_valid,
	input logic req_write,
	input dcache_pkg::addr_t req_addr,
	input dcache_pkg::word_t req_wdata,
	output logic req_ready,
	output logic rsp_valid,
	output dcache_pkg::word_t rsp_rdata,
	input logic halt,
	output logic flushed,
	// memory side
	output logic mem_valid,
	output logic mem_write,
	output dcache_pkg::addr_t mem_addr,
	output dcache_pkg::word_t mem_wdata,
	input logic mem_ready,
	input dcache_pkg::word_t mem_rdata
);
	dcache_array_if arr ();

	dcache_ctrl i_ctrl (
		.CLK(CLK),
		.nRST(nRST),
		.halt(halt),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_ready(req_ready),
		.rsp_valid(rsp_valid),
		.rsp_rdata(rsp_rdata),
		.mem_valid(mem_valid),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_ready(mem_ready),
		.mem_rdata(mem_rdata),
		.flushed(flushed),
		.arr(arr.ctrl)
	);

	dcache_store i_store (
		.CLK(CLK),
		.nRST(nRST),
		.arr(arr.store)
	);

endmodule

`default_nettype wire

/* hw/dcache_array_if.sv */
// controller to storage link
`default_nettype none
`include "dcache_cfg.svh"

interface dcache_array_if;
	dcache_pkg::idx_t idx;
	dcache_pkg::tag_t tag;
	dcache_pkg::way_t sel_way;
	logic offset; // word within block
	logic wr_en;
	dcache_pkg::word_t wr_data;
	logic wr_way_hit; // target hit way, not sel_way
	logic mark_dirty;
	logic mark_valid;
	logic mark_invalid_all;
	logic touch;

	logic hit;
	dcache_pkg::way_t hit_way;
	dcache_pkg::way_t victim_way;
	logic victim_dirty;
	dcache_pkg::tag_t victim_tag;
	logic line_valid; // sel_way at idx
	logic line_dirty;
	dcache_pkg::tag_t line_tag;
	dcache_pkg::word_t rd_word;

	modport ctrl (
		output idx, tag, sel_way, offset, wr_en, wr_data, wr_way_hit,
		output mark_dirty, mark_valid, mark_invalid_all, touch,
		input hit, hit_way, victim_way, victim_dirty, victim_tag,
		input line_valid, line_dirty, line_tag, rd_word
	);

	modport store (
		input idx, tag, sel_way, offset, wr_en, wr_data, wr_way_hit,
		input mark_dirty, mark_valid, mark_invalid_all, touch,
		output hit, hit_way, victim_way, victim_dirty, victim_tag,
		output line_valid, line_dirty, line_tag, rd_word
	);
endinterface

`default_nettype wire

/* hw/dcache_cfg.svh */
// data cache geometry
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// 32-bit words and byte addresses
`define DCACHE_WORD_BITS 32

`define DCACHE_SETS 8
`define DCACHE_IDX_BITS 3
`define DCACHE_BLK_WORDS 2

// 26 tag, 3 index, 1 word offset, 2 byte bits
`define DCACHE_TAG_BITS 26

`endif

/* hw/dcache_ctrl.sv */
// cache controller FSM
`default_nettype none
`include "dcache_cfg.svh"

module dcache_ctrl (
	input logic CLK,
	input logic nRST,
	input logic halt,
	input logic req_valid,
	input logic req_write,
	input dcache_pkg::addr_t req_addr,
	input dcache_pkg::word_t req_wdata,
	output logic req_ready,
	output logic rsp_valid,
	output dcache_pkg::word_t rsp_rdata,
	output logic mem_valid,
	output logic mem_write,
	output dcache_pkg::addr_t mem_addr,
	output dcache_pkg::word_t mem_wdata,
	input logic mem_ready,
	input dcache_pkg::word_t mem_rdata,
	output logic flushed,
	dcache_array_if.ctrl arr
);
	dcache_pkg::ctrl_state_t state, next_state;
	dcache_pkg::addr_t addr_q;
	dcache_pkg::word_t wdata_q;
	logic write_q;
	logic [`DCACHE_IDX_BITS:0] flush_cnt; // {set, way}
	logic flush_step;
	logic flush_last;
	logic serve;
	logic xfer;
	dcache_pkg::tag_t mem_tag;

	assign xfer = mem_valid && mem_ready;
	assign flush_last = &flush_cnt;
	// hit in lookup, or end of a miss
	assign serve = (state == dcache_pkg::LOOKUP && arr.hit) || state == dcache_pkg::FINISH;

	assign req_ready = state == dcache_pkg::IDLE && !halt;
	assign rsp_valid = serve;
	assign rsp_rdata = arr.rd_word;
	assign flushed = state == dcache_pkg::FLUSHED;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= dcache_pkg::IDLE;
			flush_cnt <= '0;
		end else begin
			state <= next_state;
			if (flush_step) begin
				flush_cnt <= flush_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (req_valid && req_ready) begin
			addr_q <= req_addr;
			write_q <= req_write;
			wdata_q <= req_wdata;
		end
	end

	always_comb begin
		next_state = state;
		flush_step = 1'b0;
		case (state)
			dcache_pkg::IDLE: begin
				if (halt) next_state = dcache_pkg::FLUSH_SCAN;
				else if (req_valid && req_ready) next_state = dcache_pkg::LOOKUP;
			end
			dcache_pkg::LOOKUP: begin
				if (arr.hit) next_state = dcache_pkg::IDLE;
				else if (arr.victim_dirty) next_state = dcache_pkg::WB0;
				else next_state = dcache_pkg::FILL0;
			end
			dcache_pkg::WB0: if (xfer) next_state = dcache_pkg::WB1;
			dcache_pkg::WB1: if (xfer) next_state = dcache_pkg::FILL0;
			dcache_pkg::FILL0: if (xfer) next_state = dcache_pkg::FILL1;
			dcache_pkg::FILL1: if (xfer) next_state = dcache_pkg::FINISH;
			dcache_pkg::FINISH: next_state = dcache_pkg::IDLE;
			dcache_pkg::FLUSH_SCAN: begin
				if (arr.line_valid && arr.line_dirty) next_state = dcache_pkg::FLUSH_WB0;
				else if (flush_last) next_state = dcache_pkg::FLUSHED;
				else flush_step = 1'b1;
			end
			dcache_pkg::FLUSH_WB0: if (xfer) next_state = dcache_pkg::FLUSH_WB1;
			dcache_pkg::FLUSH_WB1: begin
				if (xfer && flush_last) begin
					next_state = dcache_pkg::FLUSHED;
				end else if (xfer) begin
					next_state = dcache_pkg::FLUSH_SCAN;
					flush_step = 1'b1;
				end
			end
			default: next_state = state; // flushed holds
		endcase
	end

	always_comb begin
		arr.idx = addr_q[`DCACHE_IDX_BITS+2:3];
		arr.tag = addr_q[`DCACHE_WORD_BITS-1 -: `DCACHE_TAG_BITS];
		arr.sel_way = arr.victim_way; // miss path works on the victim
		arr.offset = addr_q[2];
		arr.wr_en = 1'b0;
		arr.wr_data = wdata_q;
		arr.wr_way_hit = 1'b0;
		arr.mark_dirty = 1'b0;
		arr.mark_valid = 1'b0;
		arr.touch = 1'b0;
		arr.mark_invalid_all = next_state == dcache_pkg::FLUSHED && state != dcache_pkg::FLUSHED;
		case (state)
			dcache_pkg::LOOKUP, dcache_pkg::FINISH: begin
				arr.wr_way_hit = 1'b1;
				arr.wr_en = serve && write_q;
				arr.mark_dirty = serve && write_q;
				arr.touch = serve;
			end
			dcache_pkg::WB0: arr.offset = 1'b0;
			dcache_pkg::WB1: arr.offset = 1'b1;
			dcache_pkg::FILL0, dcache_pkg::FILL1: begin
				arr.offset = state == dcache_pkg::FILL1;
				arr.wr_en = xfer;
				arr.wr_data = mem_rdata;
				arr.mark_valid = xfer && state == dcache_pkg::FILL1; // tag lands with last word
			end
			dcache_pkg::FLUSH_SCAN, dcache_pkg::FLUSH_WB0, dcache_pkg::FLUSH_WB1: begin
				arr.idx = flush_cnt[`DCACHE_IDX_BITS:1];
				arr.sel_way = flush_cnt[0];
				arr.tag = arr.line_tag; // steer reads to the scanned line
				arr.offset = state == dcache_pkg::FLUSH_WB1;
			end
			default: arr.offset = addr_q[2];
		endcase
	end

	always_comb begin
		mem_valid = 1'b0;
		mem_write = 1'b0;
		mem_tag = addr_q[`DCACHE_WORD_BITS-1 -: `DCACHE_TAG_BITS];
		case (state)
			dcache_pkg::WB0, dcache_pkg::WB1: begin
				mem_valid = 1'b1;
				mem_write = 1'b1;
				mem_tag = arr.victim_tag;
			end
			dcache_pkg::FILL0, dcache_pkg::FILL1: mem_valid = 1'b1;
			dcache_pkg::FLUSH_WB0, dcache_pkg::FLUSH_WB1: begin
				mem_valid = 1'b1;
				mem_write = 1'b1;
				mem_tag = arr.line_tag;
			end
			default: mem_valid = 1'b0;
		endcase
	end

	assign mem_addr = {mem_tag, arr.idx, arr.offset, 2'b00};
	assign mem_wdata = arr.rd_word;

	// memory request held until taken
	a_mem_stable: assert property (@(posedge CLK) disable iff (!nRST)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_write));

	// ready again in the cycle after a response
	a_rsp_ready: assert property (@(posedge CLK) disable iff (!nRST)
		rsp_valid |-> !req_ready ##1 (req_ready || halt));

endmodule

`default_nettype wire

/* hw/dcache_pkg.sv */
// data cache types
`default_nettype none
`include "dcache_cfg.svh"

package dcache_pkg;

	typedef logic [`DCACHE_WORD_BITS-1:0] word_t;
	typedef logic [`DCACHE_WORD_BITS-1:0] addr_t; // byte address
	typedef logic [`DCACHE_TAG_BITS-1:0] tag_t;
	typedef logic [`DCACHE_IDX_BITS-1:0] idx_t;
	typedef logic [0:0] way_t;

	typedef enum logic [3:0] {
		IDLE,
		LOOKUP,
		WB0, // victim write-back
		WB1,
		FILL0,
		FILL1,
		FINISH,
		FLUSH_SCAN,
		FLUSH_WB0,
		FLUSH_WB1,
		FLUSHED
	} ctrl_state_t;

endpackage

`default_nettype wire

/* hw/dcache_store.sv */
// two-way tag and data storage
`default_nettype none
`include "dcache_cfg.svh"

module dcache_store (
	input logic CLK,
	input logic nRST,
	dcache_array_if.store arr
);
	dcache_pkg::tag_t tag_q [2][`DCACHE_SETS];
	dcache_pkg::word_t data_q [2][`DCACHE_SETS][`DCACHE_BLK_WORDS];
	logic [`DCACHE_SETS-1:0] valid_q [2];
	logic [`DCACHE_SETS-1:0] dirty_q [2];
	logic [`DCACHE_SETS-1:0] lru_q; // names the lru way of each set
	logic [1:0] way_hit;
	dcache_pkg::way_t wr_way;
	dcache_pkg::way_t rd_way;

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid_q[w][arr.idx] && (tag_q[w][arr.idx] == arr.tag);
		end
	end

	assign arr.hit = |way_hit;
	assign arr.hit_way = way_hit[1];

	// replacement candidate
	assign arr.victim_way = lru_q[arr.idx];
	assign arr.victim_dirty = valid_q[arr.victim_way][arr.idx] &&
		dirty_q[arr.victim_way][arr.idx];
	assign arr.victim_tag = tag_q[arr.victim_way][arr.idx];

	// flush view of sel_way
	assign arr.line_valid = valid_q[arr.sel_way][arr.idx];
	assign arr.line_dirty = dirty_q[arr.sel_way][arr.idx];
	assign arr.line_tag = tag_q[arr.sel_way][arr.idx];

	assign rd_way = arr.hit ? arr.hit_way : arr.sel_way;
	assign arr.rd_word = data_q[rd_way][arr.idx][arr.offset];

	assign wr_way = arr.wr_way_hit ? arr.hit_way : arr.sel_way;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= '{default: '0};
			dirty_q <= '{default: '0};
			lru_q <= '0;
		end else if (arr.mark_invalid_all) begin
			valid_q <= '{default: '0};
			dirty_q <= '{default: '0};
		end else begin
			if (arr.mark_valid) begin // fresh fill is clean
				valid_q[arr.sel_way][arr.idx] <= 1'b1;
				dirty_q[arr.sel_way][arr.idx] <= 1'b0;
			end
			if (arr.mark_dirty) begin
				dirty_q[wr_way][arr.idx] <= 1'b1;
			end
			if (arr.touch) begin
				lru_q[arr.idx] <= ~wr_way; // other way becomes lru
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (arr.mark_valid) begin
			tag_q[arr.sel_way][arr.idx] <= arr.tag;
		end
		if (arr.wr_en) begin
			data_q[wr_way][arr.idx][arr.offset] <= arr.wr_data;
		end
	end

	// a block lives in at most one way of its set
	for (genvar s = 0; s < `DCACHE_SETS; s++) begin : g_uniq
		a_one_way: assert property (@(posedge CLK) disable iff (!nRST)
			!(valid_q[0][s] && valid_q[1][s] && tag_q[0][s] == tag_q[1][s]));
	end

endmodule

`default_nettype wire

/* tests/dcache_tb.sv */
// data cache testbench
`default_nettype none

module dcache_tb;
	localparam dcache_pkg::word_t PATTERN = 32'h5a3c_96e1;
	localparam int TIMEOUT = 200;

	logic CLK = 1'b0;
	logic nRST;
	logic req_valid;
	logic req_write;
	dcache_pkg::addr_t req_addr;
	dcache_pkg::word_t req_wdata;
	logic req_ready;
	logic rsp_valid;
	dcache_pkg::word_t rsp_rdata;
	logic halt;
	logic flushed;
	logic mem_valid;
	logic mem_write;
	dcache_pkg::addr_t mem_addr;
	dcache_pkg::word_t mem_wdata;
	logic mem_ready;
	dcache_pkg::word_t mem_rdata;
	dcache_pkg::word_t shadow [dcache_pkg::addr_t]; // last value written per address
	int errors = 0;

	always #2 CLK = ~CLK;

	dcache i_dcache (.*);
	mem_model #(.PATTERN(PATTERN)) i_mem (.*);

	function automatic dcache_pkg::word_t pattern_of(input dcache_pkg::addr_t a);
		return {2'b00, a[31:2]} ^ PATTERN;
	endfunction

	function automatic dcache_pkg::word_t expected_word(input dcache_pkg::addr_t a);
		if (shadow.exists(a)) return shadow[a];
		return pattern_of(a);
	endfunction

	task automatic expect_value(input string name, input dcache_pkg::word_t exp,
		input dcache_pkg::word_t act);
		assert (act === exp) else begin
			errors++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// one request, returns read data and cycles from acceptance to response
	task automatic access(input string name, input logic wr, input dcache_pkg::addr_t addr,
		input dcache_pkg::word_t wdata, output dcache_pkg::word_t rdata, output int lat);
		int n;
		@(negedge CLK);
		req_valid = 1'b1;
		req_write = wr;
		req_addr = addr;
		req_wdata = wdata;
		n = 0;
		while (!req_ready && n < TIMEOUT) begin
			@(negedge CLK);
			n++;
		end
		assert (req_ready) else begin
			errors++;
			$display("%s: cache never became ready for the request", name);
		end
		@(negedge CLK);
		req_valid = 1'b0;
		lat = 1;
		while (!rsp_valid && lat < TIMEOUT) begin
			@(negedge CLK);
			lat++;
		end
		assert (rsp_valid) else begin
			errors++;
			$display("%s: no response from the cache", name);
		end
		rdata = rsp_rdata;
	endtask

	task automatic read_expect(input string name, input dcache_pkg::addr_t addr, input int hit_lat);
		dcache_pkg::word_t data;
		int lat;
		access(name, 1'b0, addr, '0, data, lat);
		expect_value(name, expected_word(addr), data);
		if (hit_lat > 0) expect_value({name, " latency"}, hit_lat, lat);
	endtask

	task automatic write_word(input string name, input dcache_pkg::addr_t addr,
		input dcache_pkg::word_t data, input int hit_lat);
		dcache_pkg::word_t unused;
		int lat;
		access(name, 1'b1, addr, data, unused, lat);
		shadow[addr] = data;
		if (hit_lat > 0) expect_value({name, " latency"}, hit_lat, lat);
	endtask

	task automatic read_miss_then_hits();
		read_expect("read_miss", 32'h1008, 0);
		read_expect("read_hit", 32'h1008, 1);
		read_expect("read_hit_other", 32'h100c, 1);
	endtask

	task automatic write_hit_stays_cached();
		write_word("write_hit", 32'h100c, 32'hcafe_0001, 1);
		read_expect("write_hit_read", 32'h100c, 1);
		expect_value("write_hit_mem", pattern_of(32'h100c), i_mem.peek(32'h100c));
	endtask

	// three tags in set 1, the dirty block of 0x1008 is lru on the third
	task automatic lru_eviction();
		read_expect("lru_second_tag", 32'h1048, 0);
		read_expect("lru_third_tag", 32'h1088, 0);
		expect_value("lru_writeback", shadow[32'h100c], i_mem.peek(32'h100c));
		expect_value("lru_writeback_other", pattern_of(32'h1008), i_mem.peek(32'h1008));
		read_expect("lru_reread", 32'h100c, 0);
	endtask

	task automatic write_miss_fill();
		write_word("write_miss", 32'h2010, 32'h1234_5678, 0);
		read_expect("write_miss_read", 32'h2010, 1);
		read_expect("write_miss_other", 32'h2014, 1);
		write_word("write_miss_2", 32'h301c, 32'h0bad_f00d, 0);
		read_expect("write_miss_2_other", 32'h3018, 1);
	endtask

	task automatic halt_flush();
		int n;
		@(negedge CLK);
		halt = 1'b1;
		n = 0;
		while (!flushed && n < TIMEOUT) begin
			@(negedge CLK);
			n++;
		end
		assert (flushed) else begin
			errors++;
			$display("flushed did not rise after halt");
		end
		foreach (shadow[a]) expect_value("halt_flush", shadow[a], i_mem.peek(a));
		repeat (4) begin
			@(negedge CLK);
			assert (!req_ready) else begin
				errors++;
				$display("req_ready went high after the flush");
			end
		end
	endtask

	initial begin
		nRST = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		halt = 1'b0;
		repeat (4) @(negedge CLK);
		nRST = 1'b1;
		assert (req_ready && !rsp_valid && !mem_valid && !flushed) else begin
			errors++;
			$display("outputs not in their reset state");
		end
		read_miss_then_hits();
		write_hit_stays_cached();
		lru_eviction();
		write_miss_fill();
		halt_flush();
		$display("%0d errors", errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tests/mem_model.sv */
// testbench memory with random ready delays
`default_nettype none

module mem_model #(
	parameter dcache_pkg::word_t PATTERN = 32'h0
) (
	input logic CLK,
	input logic nRST,
	input logic mem_valid,
	input logic mem_write,
	input dcache_pkg::addr_t mem_addr,
	input dcache_pkg::word_t mem_wdata,
	output logic mem_ready,
	output dcache_pkg::word_t mem_rdata
);
	dcache_pkg::word_t words [dcache_pkg::addr_t]; // written words only
	logic [15:0] lfsr = 16'd34049;
	int delay = 0;

	initial begin
		mem_ready = 1'b0;
		mem_rdata = '0;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
	endfunction

	task automatic draw_delay();
		lfsr = lfsr_next(lfsr);
		delay = 2 * lfsr[0];
		lfsr = lfsr_next(lfsr);
		delay = delay + lfsr[0]; // 0 to 3 cycles
	endtask

	// untouched words hold word address xor pattern
	function automatic dcache_pkg::word_t peek(input dcache_pkg::addr_t a);
		dcache_pkg::addr_t key;
		key = {a[31:2], 2'b00};
		if (words.exists(key)) return words[key];
		return {2'b00, a[31:2]} ^ PATTERN;
	endfunction

	always @(negedge CLK) begin
		if (!nRST) begin
			mem_ready = 1'b0;
		end else if (mem_valid && !mem_ready) begin
			if (delay == 0) begin
				if (mem_write) words[{mem_addr[31:2], 2'b00}] = mem_wdata;
				else mem_rdata = peek(mem_addr);
				mem_ready = 1'b1; // transfer lands on the next rising edge
				draw_delay();
			end else begin
				delay--;
			end
		end else begin
			mem_ready = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_array_if.sv
hw/dcache_store.sv
hw/dcache_ctrl.sv
hw/dcache.sv
tests/mem_model.sv
tests/dcache_tb.sv
